// ==== common/uart_settings.svh ====
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Width of the bit period counters and of the stored period
`define UART_PERIOD_W 16

// Shortest run in cycles that may set the period, shorter runs are glitches
`define UART_MIN_RUN 2

`endif

// ==== common/uart_pkg.sv ====
`default_nettype none
`include "uart_settings.svh"

package uart_pkg;

   // What the baud detector reports
   typedef struct packed {
      logic [`UART_PERIOD_W-1:0] period;   // Cycles per bit
      logic                      locked;   // Any valid run seen
      logic                      resync;   // One cycle, period changed
   } baud_t;

   // Transmit request
   typedef struct packed {
      logic       valid;   // One cycle strobe
      logic [7:0] data;
   } tx_req_t;

   // Received byte
   typedef struct packed {
      logic       valid;   // One cycle strobe
      logic [7:0] data;
   } rx_byte_t;

   typedef struct packed {
      logic rx_busy;
      logic tx_busy;
   } uart_status_t;

endpackage

`default_nettype wire

// ==== uart/uart_baud_detect.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module uart_baud_detect (
   input  wire             i_clk,
   input  wire             i_nrst,
   input  wire             i_rx,
   output logic            o_rx_sync,
   output uart_pkg::baud_t o_baud
);

   logic [1:0]                sync_q;     // Two-flop synchronizer
   logic                      rx_prev;
   logic                      edge_seen;
   logic [`UART_PERIOD_W-1:0] run_cnt;
   uart_pkg::baud_t           baud_q;

   assign o_rx_sync = sync_q[1];
   assign edge_seen = sync_q[1] ^ rx_prev;
   assign o_baud    = baud_q;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         sync_q  <= 2'b11;   // Line idles high
         rx_prev <= 1'b1;
      end else begin
         sync_q  <= {sync_q[0], i_rx};
         rx_prev <= sync_q[1];
      end
   end

   // Run length of the current level, saturating.
   // Starts saturated so the run before the first edge never counts.
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         run_cnt <= '1;
      end else if (edge_seen) begin
         run_cnt <= `UART_PERIOD_W'(1);
      end else if (run_cnt != '1) begin
         run_cnt <= run_cnt + 1'b1;
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         baud_q.period <= '1;
         baud_q.locked <= 1'b0;
         baud_q.resync <= 1'b0;
      end else begin
         baud_q.resync <= 1'b0;
         if (edge_seen && run_cnt >= `UART_PERIOD_W'(`UART_MIN_RUN)
             && run_cnt < baud_q.period) begin
            baud_q.period <= run_cnt;   // Shortest run so far
            baud_q.locked <= 1'b1;
            baud_q.resync <= 1'b1;
         end
      end
   end

   // A resync only ever follows a shrink to a valid period
   resync_period_a: assert property (@(posedge i_clk) disable iff (!i_nrst)
      baud_q.resync |-> (baud_q.period >= `UART_PERIOD_W'(`UART_MIN_RUN))
                        && (baud_q.period < $past(baud_q.period)));

endmodule

`default_nettype wire

// ==== uart/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module uart_rx (
   input  wire                 i_clk,
   input  wire                 i_nrst,
   input  wire                 i_rx_sync,
   input  wire uart_pkg::baud_t i_baud,
   output uart_pkg::rx_byte_t  o_rx_byte,
   output logic                o_busy
);

   typedef enum logic [3:0] {
      RX_IDLE,
      RX_START,
      RX_D0, RX_D1, RX_D2, RX_D3, RX_D4, RX_D5, RX_D6, RX_D7,
      RX_WAIT
   } rx_state_e;

   rx_state_e                 state;
   logic [`UART_PERIOD_W-1:0] cnt;
   logic [`UART_PERIOD_W-1:0] half_last;
   logic [`UART_PERIOD_W-1:0] bit_last;
   logic                      sample;
   logic [7:0]                shift;
   logic                      valid_q;

   assign half_last = (i_baud.period >> 1) - 1'b1;   // Middle of start bit
   assign bit_last  = i_baud.period - 1'b1;
   assign sample    = (state inside {[RX_D0:RX_D7]}) && (cnt == bit_last);

   assign o_rx_byte = '{valid: valid_q, data: shift};

   // LSB arrives first
   always_ff @(posedge i_clk) begin
      if (sample) begin
         shift <= {i_rx_sync, shift[7:1]};
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= RX_IDLE;
         cnt     <= '0;
         valid_q <= 1'b0;
         o_busy  <= 1'b0;
      end else begin
         cnt     <= cnt + 1'b1;
         valid_q <= 1'b0;
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               if (!i_rx_sync) begin   // Start bit
                  state  <= RX_START;
                  o_busy <= 1'b1;
               end
            end
            RX_START: begin
               if (cnt == half_last) begin
                  state <= RX_D0;
                  cnt   <= '0;
               end
            end
            RX_D0, RX_D1, RX_D2, RX_D3, RX_D4, RX_D5, RX_D6: begin
               if (sample) begin
                  state <= rx_state_e'(state + 1'b1);
                  cnt   <= '0;
               end
            end
            RX_D7: begin
               if (sample) begin
                  state   <= RX_WAIT;
                  cnt     <= '0;
                  valid_q <= 1'b1;
               end
            end
            RX_WAIT: begin
               if (i_rx_sync) begin   // Back to stop level
                  state  <= RX_IDLE;
                  o_busy <= 1'b0;
               end
            end
            default: begin
               state  <= RX_IDLE;
               o_busy <= 1'b0;
            end
         endcase
         if (i_baud.resync) begin
            cnt <= '0;   // Period just changed
         end
      end
   end

   valid_single_a: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_rx_byte.valid |=> !o_rx_byte.valid);

endmodule

`default_nettype wire

// ==== uart/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module uart_tx (
   input  wire                   i_clk,
   input  wire                   i_nrst,
   input  wire uart_pkg::tx_req_t i_req,
   input  wire uart_pkg::baud_t  i_baud,
   output logic                  o_tx,
   output logic                  o_busy
);

   // In TX_Dn the previous level is on the line and bit n goes out next
   typedef enum logic [3:0] {
      TX_IDLE,
      TX_D0, TX_D1, TX_D2, TX_D3, TX_D4, TX_D5, TX_D6, TX_D7,
      TX_STOP,
      TX_GUARD
   } tx_state_e;

   tx_state_e                 state;
   logic [`UART_PERIOD_W-1:0] cnt;
   logic [`UART_PERIOD_W-1:0] bit_last;
   logic                      bit_done;
   logic                      accept;
   logic                      guard_second;   // Stop bit over, guard time running
   logic [7:0]                shift;

   assign bit_last = i_baud.period - 1'b1;
   assign bit_done = (cnt == bit_last);
   assign accept   = (state == TX_IDLE) && i_req.valid && i_baud.locked;

   always_ff @(posedge i_clk) begin
      if (accept) begin
         shift <= i_req.data;
      end else if (bit_done && (state inside {[TX_D0:TX_D7]})) begin
         shift <= shift >> 1;
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state        <= TX_IDLE;
         cnt          <= '0;
         o_tx         <= 1'b1;
         o_busy       <= 1'b0;
         guard_second <= 1'b0;
      end else begin
         cnt <= cnt + 1'b1;
         case (state)
            TX_IDLE: begin
               cnt <= '0;
               if (accept) begin
                  state  <= TX_D0;
                  o_tx   <= 1'b0;   // Start bit
                  o_busy <= 1'b1;
               end
            end
            TX_D0, TX_D1, TX_D2, TX_D3, TX_D4, TX_D5, TX_D6, TX_D7: begin
               if (bit_done) begin
                  o_tx  <= shift[0];
                  cnt   <= '0;
                  state <= tx_state_e'(state + 1'b1);   // D7 moves on to stop
               end
            end
            TX_STOP: begin
               if (bit_done) begin
                  o_tx  <= 1'b1;
                  cnt   <= '0;
                  state <= TX_GUARD;
               end
            end
            TX_GUARD: begin
               if (bit_done) begin
                  cnt <= '0;
                  if (guard_second) begin
                     state        <= TX_IDLE;
                     o_busy       <= 1'b0;
                     guard_second <= 1'b0;
                  end else begin
                     guard_second <= 1'b1;
                  end
               end
            end
            default: begin
               state  <= TX_IDLE;
               o_tx   <= 1'b1;
               o_busy <= 1'b0;
            end
         endcase
         if (i_baud.resync) begin
            cnt <= '0;
         end
      end
   end

   idle_line_high_a: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !o_busy |-> o_tx);

endmodule

`default_nettype wire

// ==== verilog/uart_autobaud_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_autobaud_top (
   input  wire                    i_clk,
   input  wire                    i_nrst,
   input  wire                    i_rx,
   input  wire uart_pkg::tx_req_t i_tx_req,
   output logic                   o_tx,
   output uart_pkg::rx_byte_t     o_rx_byte,
   output uart_pkg::uart_status_t o_status,
   output uart_pkg::baud_t        o_baud
);

   logic            rx_sync;   // Only synchronized copy of the line
   logic            rx_busy;
   logic            tx_busy;
   uart_pkg::baud_t baud;

   assign o_baud   = baud;
   assign o_status = '{rx_busy: rx_busy, tx_busy: tx_busy};

   uart_baud_detect uart_baud_detect_inst (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_rx      (i_rx),
      .o_rx_sync (rx_sync),
      .o_baud    (baud)
   );

   uart_rx uart_rx_inst (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_rx_sync (rx_sync),
      .i_baud    (baud),
      .o_rx_byte (o_rx_byte),
      .o_busy    (rx_busy)
   );

   uart_tx uart_tx_inst (
      .i_clk  (i_clk),
      .i_nrst (i_nrst),
      .i_req  (i_tx_req),
      .i_baud (baud),
      .o_tx   (o_tx),
      .o_busy (tx_busy)
   );

endmodule

`default_nettype wire

// ==== test/tb_uart_autobaud.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module tb_uart_autobaud;

   logic                   i_clk = 1'b0;
   logic                   i_nrst;
   logic                   i_rx;
   uart_pkg::tx_req_t      i_tx_req;
   logic                   o_tx;
   uart_pkg::rx_byte_t     o_rx_byte;
   uart_pkg::uart_status_t o_status;
   uart_pkg::baud_t        o_baud;

   int                     bit_cycles;          // Bit period used by the decoder
   logic [31:0]            lfsr = 32'h43a5;
   int                     value_errors = 0;
   int                     timeout_errors = 0;
   int                     rx_count;
   uart_pkg::rx_byte_t     rx_last;
   uart_pkg::uart_status_t rx_status;           // Status in the strobe cycle
   uart_pkg::baud_t        resync_baud;         // Detector output at the last resync

   always #10 i_clk = ~i_clk;

   uart_autobaud_top uart_autobaud_top_inst (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_rx      (i_rx),
      .i_tx_req  (i_tx_req),
      .o_tx      (o_tx),
      .o_rx_byte (o_rx_byte),
      .o_status  (o_status),
      .o_baud    (o_baud)
   );

   // Received byte strobes and period changes
   always @(negedge i_clk) begin
      if (o_rx_byte.valid) begin
         rx_count  = rx_count + 1;
         rx_last   = o_rx_byte;
         rx_status = o_status;
      end
      if (o_baud.resync) begin
         resync_baud = o_baud;
      end
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic next_byte(output logic [7:0] v);
      for (int i = 0; i < 8; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {lfsr[0], v[7:1]};
      end
   endtask

   task automatic check_rx_byte(input string name, input uart_pkg::rx_byte_t got,
                                input uart_pkg::rx_byte_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_status(input string name, input uart_pkg::uart_status_t got,
                               input uart_pkg::uart_status_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_line(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         value_errors++;
         $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      end
   endtask

   // Period may be off by one cycle
   task automatic check_baud(input string name, input uart_pkg::baud_t got,
                             input uart_pkg::baud_t exp);
      if ($isunknown(got) || got.locked != exp.locked || got.resync != exp.resync
          || got.period > exp.period + 1 || got.period + 1 < exp.period) begin
         value_errors++;
         $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) @(posedge i_clk);
   endtask

   // Each 8N1 level held for exactly cycles clocks
   task automatic drive_frame(input logic [7:0] data, input int cycles);
      logic [9:0] levels;
      levels = {1'b1, data, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge i_clk);
         i_rx <= levels[i];
         repeat (cycles - 1) @(posedge i_clk);
      end
   endtask

   task automatic receive_frame(input logic [7:0] data, input int cycles);
      int waited;
      rx_count = 0;
      waited   = 0;
      drive_frame(data, cycles);
      while (rx_count == 0 && waited < 4 * cycles) begin
         @(posedge i_clk);
         waited++;
      end
      idle(2 * cycles);
      @(negedge i_clk);
      if (rx_count == 0) begin
         timeout_errors++;
         $display("Timeout: no byte was received for the frame carrying %h", data);
      end else begin
         if (rx_count != 1) begin
            value_errors++;
            $display("CHECK FAILED rx strobe count: got %h expected %h", rx_count, 1);
         end
         check_rx_byte("o_rx_byte", rx_last, '{valid: 1'b1, data: data});
         check_status("o_status at rx strobe", rx_status, '{rx_busy: 1'b1, tx_busy: 1'b0});
         check_status("o_status", o_status, '{rx_busy: 1'b0, tx_busy: 1'b0});
      end
   endtask

   task automatic send_tx_request(input logic [7:0] data);
      @(posedge i_clk);
      i_tx_req <= '{valid: 1'b1, data: data};
      @(posedge i_clk);
      i_tx_req <= '{valid: 1'b0, data: 8'h00};
   endtask

   // Samples o_tx mid-bit at the testbench's own bit period
   task automatic decode_tx_frame(input logic [7:0] exp_data);
      int         waited;
      logic [9:0] bits;
      logic [9:0] expected;
      waited   = 0;
      expected = {1'b1, exp_data, 1'b0};
      @(negedge i_clk);
      while (o_tx !== 1'b0 && waited < 8 * bit_cycles) begin
         @(negedge i_clk);
         waited++;
      end
      if (o_tx !== 1'b0) begin
         timeout_errors++;
         $display("Timeout: the transmitter never sent a start bit");
         return;
      end
      repeat (bit_cycles / 2) @(negedge i_clk);
      for (int i = 0; i < 10; i++) begin
         bits[i] = o_tx;
         check_status("o_status", o_status, '{rx_busy: 1'b0, tx_busy: 1'b1});
         if (i < 9) begin
            repeat (bit_cycles) @(negedge i_clk);
         end
      end
      for (int i = 0; i < 10; i++) begin
         check_line($sformatf("o_tx level %0d", i), bits[i], expected[i]);
      end
      // Guard bit time after the stop bit
      repeat (bit_cycles) @(negedge i_clk);
      check_line("o_tx guard", o_tx, 1'b1);
      check_status("o_status", o_status, '{rx_busy: 1'b0, tx_busy: 1'b1});
      waited = 0;
      while (o_status.tx_busy !== 1'b0 && waited < 3 * bit_cycles) begin
         @(negedge i_clk);
         waited++;
      end
      if (o_status.tx_busy !== 1'b0) begin
         timeout_errors++;
         $display("Timeout: tx_busy stayed high after the frame");
      end else begin
         check_status("o_status", o_status, '{rx_busy: 1'b0, tx_busy: 1'b0});
      end
   endtask

   // No frame may start in this window
   task automatic watch_line_idle(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         @(negedge i_clk);
         if (o_tx !== 1'b1 || o_status.tx_busy !== 1'b0) begin
            check_line("o_tx", o_tx, 1'b1);
            check_status("o_status", o_status, '{rx_busy: 1'b0, tx_busy: 1'b0});
            break;
         end
      end
   endtask

   task automatic test_reset_and_lock();
      @(negedge i_clk);
      check_baud("o_baud", o_baud, '{period: '1, locked: 1'b0, resync: 1'b0});
      check_line("o_tx", o_tx, 1'b1);
      check_status("o_status", o_status, '{rx_busy: 1'b0, tx_busy: 1'b0});
      send_tx_request(8'ha7);   // Not locked yet
      watch_line_idle(200);
      resync_baud = '0;
      drive_frame(8'h55, 40);
      idle(80);
      @(negedge i_clk);
      check_baud("o_baud at resync", resync_baud,
                 '{period: `UART_PERIOD_W'(40), locked: 1'b1, resync: 1'b1});
      check_baud("o_baud", o_baud,
                 '{period: `UART_PERIOD_W'(40), locked: 1'b1, resync: 1'b0});
   endtask

   task automatic test_receive();
      logic [7:0] b;
      for (int i = 0; i < 8; i++) begin
         next_byte(b);
         receive_frame(b, 40);
      end
   endtask

   task automatic test_transmit();
      logic [7:0] b;
      next_byte(b);
      send_tx_request(b);
      decode_tx_frame(b);
   endtask

   task automatic test_drop_while_busy();
      logic [7:0] b;
      logic [7:0] b2;
      next_byte(b);
      next_byte(b2);
      fork
         begin
            send_tx_request(b);
            decode_tx_frame(b);
         end
         begin
            idle(100);
            send_tx_request(b2);   // Lands mid-frame
         end
      join
      watch_line_idle(12 * bit_cycles);
   endtask

   task automatic test_faster_rate();
      logic [7:0] b;
      bit_cycles  = 24;
      resync_baud = '0;
      drive_frame(8'h55, 24);
      idle(48);
      @(negedge i_clk);
      check_baud("o_baud at resync", resync_baud,
                 '{period: `UART_PERIOD_W'(24), locked: 1'b1, resync: 1'b1});
      check_baud("o_baud", o_baud,
                 '{period: `UART_PERIOD_W'(24), locked: 1'b1, resync: 1'b0});
      for (int i = 0; i < 4; i++) begin
         next_byte(b);
         receive_frame(b, 24);
      end
      next_byte(b);
      send_tx_request(b);
      decode_tx_frame(b);
      next_byte(b);
      drive_frame(b, 40);   // Slower frame must not raise the period
      idle(80);
      @(negedge i_clk);
      check_baud("o_baud", o_baud,
                 '{period: `UART_PERIOD_W'(24), locked: 1'b1, resync: 1'b0});
   endtask

   initial begin
      i_nrst      = 1'b0;
      i_rx        = 1'b1;
      i_tx_req    = '0;
      bit_cycles  = 40;
      rx_count    = 0;
      rx_last     = '0;
      rx_status   = '0;
      resync_baud = '0;
      repeat (3) @(posedge i_clk);
      i_nrst <= 1'b1;
      test_reset_and_lock();
      test_receive();
      test_transmit();
      test_drop_while_busy();
      test_faster_rate();
      $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
      if (value_errors == 0 && timeout_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/uart_pkg.sv
uart/uart_baud_detect.sv
uart/uart_rx.sv
uart/uart_tx.sv
verilog/uart_autobaud_top.sv
test/tb_uart_autobaud.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART autobaud testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module tb_uart_autobaud -f verilog.f \
   --Mdir obj_dir -o tb_uart_autobaud
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_uart_autobaud > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -F -q "*** TEST PASSED ***" "$LOG"; then
   exit 0
fi
exit 1
